// File: source/tlb_pkg.sv
//****************************************
// TLB shared types, page-size codes,
// age constants and geometry
//****************************************
package tlb_pkg;

	// Named vector widths
	typedef logic [31:0] vaddr_t;	// Virtual address
	typedef logic [13:0] asid_t;	// Address-space id
	typedef logic [16:0] tag_t;	// Stored virtual tag
	typedef logic [1:0] index_t;	// Set number
	typedef logic [1:0] way_t;	// Way number
	typedef logic [2:0] ps_t;	// Page-size code
	typedef logic [19:0] ppn_t;	// Physical page number
	typedef logic [11:0] flags_t;	// Flags of one page
	typedef logic [1:0] age_t;	// Way age where 0 means empty

	// Second-level page sizes
	// Code k selects a page of 4K << k
	localparam ps_t PS_4K = 3'd0;
	localparam ps_t PS_8K = 3'd1;
	localparam ps_t PS_16K = 3'd2;
	localparam ps_t PS_32K = 3'd3;
	localparam ps_t PS_64K = 3'd4;

	// Ages
	localparam age_t AGE_EMPTY = 2'd0;
	localparam age_t AGE_NEWEST = 2'd3;

	// Set count is tied to the two index bits
	localparam int SETS = 4;
	localparam int DEF_WAYS = 4;

endpackage

// File: source/tlb_if.sv
//****************************************
// Lookup and fill interfaces
//****************************************

// Read lookup whose address-space id comes straight from the read port
interface tlb_lookup_if (input tlb_pkg::asid_t asid);

	tlb_pkg::index_t index;
	tlb_pkg::tag_t tag;
	logic hit;
	tlb_pkg::way_t hit_way;	// Valid only with hit

	modport requester (
		input index,
		input hit,
		input hit_way
	);

	modport responder (
		input index,
		input tag,
		input asid,
		output hit,
		output hit_way
	);

endinterface

// Line fill where the age table picks the way
interface tlb_fill_if (input tlb_pkg::asid_t asid);

	logic en;
	tlb_pkg::index_t index;
	tlb_pkg::way_t way;
	tlb_pkg::tag_t tag;

	modport filler (
		input en,
		input index,
		output way
	);

	modport store (
		input en,
		input index,
		input way,
		input tag,
		input asid
	);

endinterface

// File: source/tlb_addr_split.sv
//****************************************
// Virtual address slicing into index,
// tag and line select per page size
//****************************************
module tlb_addr_split (
	input tlb_pkg::vaddr_t addr,
	input tlb_pkg::ps_t ps,
	output tlb_pkg::index_t index,
	output tlb_pkg::tag_t tag,
	output logic line
);

	tlb_pkg::vaddr_t shifted;

	// Shifting by the size code lines every page size up with 4K
	always_comb begin
		case (ps)
			tlb_pkg::PS_4K,
			tlb_pkg::PS_8K,
			tlb_pkg::PS_16K,
			tlb_pkg::PS_32K,
			tlb_pkg::PS_64K: begin
				shifted = addr >> ps;
			end
			default: begin
				shifted = '0;	// Unknown size
			end
		endcase
	end

	// Upper bits shift in as zero, so the tag comes out zero-extended
	assign index = shifted[14:13];
	assign tag = shifted[31:15];
	assign line = shifted[12];	// Which half of the page pair

endmodule

// File: source/tlb_ctrl.sv
//****************************************
// Request-valid register, stall lock and
// fill / aging priority
//****************************************
module tlb_ctrl (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic rd_req,
	input logic rd_stall,
	input logic wr_req,
	output logic fill_en,
	output logic age_en,
	output logic hold,
	output logic rd_valid
);

	logic req_valid;

	// Loaded only while the downstream side accepts
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_valid <= 1'b0;
		end else if (flush) begin
			req_valid <= 1'b0;
		end else if (!rd_stall) begin
			req_valid <= rd_req;
		end
	end

	// Flush beats fill, fill beats aging
	assign fill_en = wr_req && !flush;

	// Accepted read that does not collide with a fill
	assign age_en = rd_req && !rd_stall && !wr_req && !flush;

	assign hold = rd_stall;	// Freeze the read registers

	assign rd_valid = req_valid && !rd_stall;

endmodule

// File: source/tlb_tag_array.sv
//****************************************
// Tag and address-space storage with
// per-way hit compare
//****************************************
module tlb_tag_array #(
	parameter int WAYS = 4
) (
	input logic iCLOCK,
	tlb_fill_if.store fill,
	tlb_lookup_if.responder lookup,
	input logic [WAYS-1:0] valid_ways
);

	tlb_pkg::tag_t tags [tlb_pkg::SETS][WAYS];
	tlb_pkg::asid_t asids [tlb_pkg::SETS][WAYS];

	// Fill writes one way of one set
	always_ff @(posedge iCLOCK) begin
		if (fill.en) begin
			tags[fill.index][fill.way] <= fill.tag;
			asids[fill.index][fill.way] <= fill.asid;
		end
	end

	// Hit compare against the read set
	// Scanning downwards lets the lowest matching way win
	always_comb begin
		lookup.hit = 1'b0;
		lookup.hit_way = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (valid_ways[w]
					&& tags[lookup.index][w] == lookup.tag
					&& asids[lookup.index][w] == lookup.asid) begin
				lookup.hit = 1'b1;
				lookup.hit_way = tlb_pkg::way_t'(w);
			end
		end
	end

endmodule

// File: source/tlb_age_table.sv
//****************************************
// Way ages, fill-way search and aging
//****************************************
module tlb_age_table #(
	parameter int WAYS = 4
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic age_en,
	tlb_lookup_if.requester lookup,
	tlb_fill_if.filler fill,
	output logic [WAYS-1:0] valid_ways
);

	tlb_pkg::age_t ages [tlb_pkg::SETS][WAYS];

	// Fill way for the write set
	// Oldest age first, lowest way within an age, else the last way
	always_comb begin
		logic found;
		found = 1'b0;
		fill.way = tlb_pkg::way_t'(WAYS - 1);
		for (int a = 0; a < 3; a++) begin
			for (int w = 0; w < WAYS; w++) begin
				if (!found && ages[fill.index][w] == tlb_pkg::age_t'(a)) begin
					fill.way = tlb_pkg::way_t'(w);
					found = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int s = 0; s < tlb_pkg::SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					ages[s][w] <= tlb_pkg::AGE_EMPTY;
				end
			end
		end else if (flush) begin
			for (int s = 0; s < tlb_pkg::SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					ages[s][w] <= tlb_pkg::AGE_EMPTY;
				end
			end
		end else if (fill.en) begin
			ages[fill.index][fill.way] <= tlb_pkg::AGE_NEWEST;
		end else if (age_en) begin
			// Refresh the hit way, every other way in every set decays
			for (int s = 0; s < tlb_pkg::SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					if (lookup.hit && lookup.index == tlb_pkg::index_t'(s)
							&& lookup.hit_way == tlb_pkg::way_t'(w)) begin
						ages[s][w] <= tlb_pkg::AGE_NEWEST;
					end else if (ages[s][w] >= tlb_pkg::age_t'(2)) begin
						ages[s][w] <= ages[s][w] - tlb_pkg::age_t'(1);	// Never below 1
					end
				end
			end
		end
	end

	// Occupied ways of the read set
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			valid_ways[w] = ages[lookup.index][w] != tlb_pkg::AGE_EMPTY;
		end
	end

endmodule

// File: source/tlb_data_array.sv
//****************************************
// Physical page pairs and flags with
// registered read and output select
//****************************************
module tlb_data_array #(
	parameter int WAYS = 4
) (
	input logic iCLOCK,
	input logic inRESET,
	tlb_fill_if.store fill,
	input tlb_pkg::ps_t wr_ps,
	input logic [63:0] wr_phys_addr,
	tlb_lookup_if.requester lookup,
	input logic rd_line,
	input logic hold,
	input logic rd_valid,
	output logic rd_hit,
	output tlb_pkg::flags_t [1:0] rd_flags,
	output logic [31:0] rd_phys_addr
);

	tlb_pkg::ppn_t pages [tlb_pkg::SETS][WAYS][2];
	tlb_pkg::flags_t [1:0] flags [tlb_pkg::SETS][WAYS];

	logic b_hit;
	tlb_pkg::way_t b_way;
	tlb_pkg::index_t b_index;
	logic b_line;
	logic sel;

	// Drop the page-offset bits that lie above 4K
	function automatic tlb_pkg::ppn_t clear_low(input tlb_pkg::ppn_t ppn,
			input tlb_pkg::ps_t k);
		return (ppn >> k) << k;
	endfunction

	// Lower half of the write data is line 0, upper half line 1
	always_ff @(posedge iCLOCK) begin
		if (fill.en) begin
			pages[fill.index][fill.way][0] <= clear_low(wr_phys_addr[31:12], wr_ps);
			pages[fill.index][fill.way][1] <= clear_low(wr_phys_addr[63:44], wr_ps);
			flags[fill.index][fill.way] <= {wr_phys_addr[43:32], wr_phys_addr[11:0]};
		end
	end

	// Lookup result frozen under back-pressure
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_hit <= 1'b0;
			b_way <= '0;
			b_index <= '0;
			b_line <= 1'b0;
		end else if (!hold) begin
			b_hit <= lookup.hit;
			b_way <= lookup.hit_way;
			b_index <= lookup.index;
			b_line <= rd_line;
		end
	end

	assign sel = rd_valid && b_hit;

	assign rd_hit = sel;
	assign rd_flags = sel ? flags[b_index][b_way] : '0;
	assign rd_phys_addr = sel ? {pages[b_index][b_way][b_line], 12'h000} : 32'h0;

endmodule

// File: source/tlb_top.sv
//****************************************
// TLB top level, four sets, page pairs
//****************************************
module tlb_top #(
	parameter int WAYS = tlb_pkg::DEF_WAYS
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,	// Empties every way
	// Read
	input logic rd_req,
	output logic rd_busy,
	input tlb_pkg::asid_t rd_asid,
	input tlb_pkg::ps_t rd_ps,
	input tlb_pkg::vaddr_t rd_addr,
	output logic rd_valid,
	input logic rd_stall,
	output logic rd_hit,
	output tlb_pkg::flags_t [1:0] rd_flags,
	output logic [31:0] rd_phys_addr,
	// Write
	input logic wr_req,
	input tlb_pkg::asid_t wr_asid,
	input tlb_pkg::ps_t wr_ps,
	input tlb_pkg::vaddr_t wr_addr,
	input logic [63:0] wr_phys_addr
);

	logic age_en;
	logic rd_line;
	logic [WAYS-1:0] valid_ways;

	tlb_lookup_if lookup_bus (.asid(rd_asid));
	tlb_fill_if fill_bus (.asid(wr_asid));

	// The stall lock doubles as the busy output
	tlb_ctrl ctrl_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.rd_req(rd_req),
		.rd_stall(rd_stall),
		.wr_req(wr_req),
		.fill_en(fill_bus.en),
		.age_en(age_en),
		.hold(rd_busy),
		.rd_valid(rd_valid)
	);

	tlb_addr_split rd_split_i (
		.addr(rd_addr),
		.ps(rd_ps),
		.index(lookup_bus.index),
		.tag(lookup_bus.tag),
		.line(rd_line)
	);

	tlb_addr_split wr_split_i (
		.addr(wr_addr),
		.ps(wr_ps),
		.index(fill_bus.index),
		.tag(fill_bus.tag),
		.line()	// A fill writes both halves
	);

	tlb_tag_array #(.WAYS(WAYS)) tag_array_i (
		.iCLOCK(iCLOCK),
		.fill(fill_bus.store),
		.lookup(lookup_bus.responder),
		.valid_ways(valid_ways)
	);

	tlb_age_table #(.WAYS(WAYS)) age_table_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.age_en(age_en),
		.lookup(lookup_bus.requester),
		.fill(fill_bus.filler),
		.valid_ways(valid_ways)
	);

	tlb_data_array #(.WAYS(WAYS)) data_array_i (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.fill(fill_bus.store),
		.wr_ps(wr_ps),
		.wr_phys_addr(wr_phys_addr),
		.lookup(lookup_bus.requester),
		.rd_line(rd_line),
		.hold(rd_busy),
		.rd_valid(rd_valid),
		.rd_hit(rd_hit),
		.rd_flags(rd_flags),
		.rd_phys_addr(rd_phys_addr)
	);

endmodule

// File: bench/tlb_clkgen.sv
//****************************************
// Clock and reset generator
//****************************************
module tlb_clkgen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic iCLOCK,
	output logic inRESET
);

	initial begin
		iCLOCK = 1'b0;
		forever #(PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	// Release away from the rising edge
	initial begin
		inRESET = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
	end

endmodule

// File: bench/tlb_chk.sv
//****************************************
// Read handshake assertions, bound
// into the TLB top level
//****************************************
module tlb_chk (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic rd_req,
	input logic rd_stall,
	input logic rd_busy,
	input logic rd_valid,
	input logic rd_hit,
	input logic [23:0] rd_flags,
	input logic [31:0] rd_phys_addr
);

	int fail_count = 0;	// Read back by the testbench

	assert property (@(posedge iCLOCK) disable iff (!inRESET) rd_busy == rd_stall)
	else begin
		$error("rd_busy does not follow rd_stall");
		fail_count++;
	end

	// Accepted request shows up one cycle later unless stalled again
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_req && !rd_stall && !flush |=> rd_valid || rd_stall)
	else begin
		$error("rd_valid missing one cycle after an accepted request");
		fail_count++;
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		rd_stall |-> !rd_valid && !rd_hit && rd_flags == '0 && rd_phys_addr == '0)
	else begin
		$error("read outputs not quiet while stalled");
		fail_count++;
	end

	// No hit, no data
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!rd_hit |-> rd_flags == '0 && rd_phys_addr == '0)
	else begin
		$error("read data present without a hit");
		fail_count++;
	end

endmodule

bind tlb_top tlb_chk protocol_chk_i (.*);

// File: bench/tlb_tb.sv
//****************************************
// TLB testbench with reference model,
// fills, reads, flush and stalls
//****************************************
module tlb_tb;

	localparam int WAYS = 4;
	localparam int TIMEOUT_CYCLES = 2000;	// Tests need about 150 cycles

	logic iCLOCK, inRESET, flush, rd_req, rd_stall, wr_req;
	logic rd_busy, rd_valid, rd_hit;
	tlb_pkg::asid_t rd_asid, wr_asid;
	tlb_pkg::ps_t rd_ps, wr_ps;
	tlb_pkg::vaddr_t rd_addr, wr_addr;
	logic [63:0] wr_phys_addr;
	tlb_pkg::flags_t [1:0] rd_flags;
	logic [31:0] rd_phys_addr;

	int seed = 25206;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// Reference model state
	logic [16:0] m_tag [4][WAYS];
	logic [13:0] m_asid [4][WAYS];
	logic [19:0] m_ppn [4][WAYS][2];
	logic [23:0] m_flags [4][WAYS];
	logic [1:0] m_age [4][WAYS] = '{default: 2'd0};

	tlb_clkgen #(.PERIOD(10), .RESET_CYCLES(3)) clkgen_i (.iCLOCK(iCLOCK), .inRESET(inRESET));

	tlb_top tlb_top_i (.*);

	function automatic logic [1:0] set_of(input logic [31:0] addr, input int k);
		return addr[13 + k +: 2];
	endfunction

	function automatic logic [16:0] tag_of(input logic [31:0] addr, input int k);
		return 17'(addr >> (15 + k));
	endfunction

	// 4K page in a given set
	function automatic logic [31:0] line_addr(input int t, input int s);
		return (32'(t) << 15) | (32'(s) << 13);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic fill_line(input logic [31:0] addr, input logic [13:0] asid, input int k,
			input logic [63:0] phys);
		logic [1:0] s;
		logic [19:0] mask;
		int way;
		s = set_of(addr, k);
		mask = ~((20'd1 << k) - 20'd1);
		way = WAYS - 1;	// No young way left
		for (int a = 2; a >= 0; a--) begin
			for (int w = WAYS - 1; w >= 0; w--) begin
				if (m_age[s][w] == 2'(a)) way = w;
			end
		end
		m_tag[s][way] = tag_of(addr, k);
		m_asid[s][way] = asid;
		m_ppn[s][way][0] = phys[31:12] & mask;
		m_ppn[s][way][1] = phys[63:44] & mask;
		m_flags[s][way] = {phys[43:32], phys[11:0]};
		m_age[s][way] = 2'd3;
		@(negedge iCLOCK);
		wr_req = 1'b1;
		wr_addr = addr;
		wr_asid = asid;
		wr_ps = 3'(k);
		wr_phys_addr = phys;
		@(negedge iCLOCK);
		wr_req = 1'b0;
	endtask

	// Lookup plus the aging of an accepted read
	task automatic model_read(input logic [31:0] addr, input logic [13:0] asid, input int k,
			output logic hit, output int way);
		logic [1:0] s;
		s = set_of(addr, k);
		hit = 1'b0;
		way = 0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (m_age[s][w] != 2'd0 && m_tag[s][w] == tag_of(addr, k)
					&& m_asid[s][w] == asid) begin
				hit = 1'b1;
				way = w;
			end
		end
		for (int i = 0; i < 4; i++) begin
			for (int w = 0; w < WAYS; w++) begin
				if (hit && i == s && w == way) m_age[i][w] = 2'd3;
				else if (m_age[i][w] >= 2'd2) m_age[i][w] = m_age[i][w] - 2'd1;
			end
		end
	endtask

	task automatic drive_read(input logic [31:0] addr, input logic [13:0] asid, input int k);
		@(negedge iCLOCK);
		rd_req = 1'b1;
		rd_addr = addr;
		rd_asid = asid;
		rd_ps = 3'(k);
	endtask

	task automatic compare_result(input logic hit, input logic [1:0] s, input int way,
			input logic line);
		check_value("rd_valid", rd_valid, 1);
		check_value("rd_hit", rd_hit, hit);
		check_value("rd_phys_addr", rd_phys_addr, hit ? {m_ppn[s][way][line], 12'h000} : 32'h0);
		check_value("rd_flags", rd_flags, hit ? m_flags[s][way] : 24'h0);
	endtask

	task automatic read_check(input logic [31:0] addr, input logic [13:0] asid, input int k,
			input logic exp_hit);
		logic hit;
		int way;
		model_read(addr, asid, k, hit, way);
		drive_read(addr, asid, k);
		@(negedge iCLOCK);	// Result is due one cycle after acceptance
		rd_req = 1'b0;
		compare_result(hit, set_of(addr, k), way, addr[12 + k]);
		check_value("rd_hit (scenario)", rd_hit, exp_hit);
	endtask

	task automatic flush_all();
		@(negedge iCLOCK);
		flush = 1'b1;
		@(negedge iCLOCK);
		flush = 1'b0;
		m_age = '{default: 2'd0};
	endtask

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge iCLOCK);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not finish", cycles);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [31:0] addr;
		logic [13:0] asid;
		logic [63:0] phys;
		logic hit;
		int way;
		flush = 1'b0;
		rd_req = 1'b0;
		rd_stall = 1'b0;
		wr_req = 1'b0;
		rd_asid = '0;
		rd_ps = '0;
		rd_addr = '0;
		wr_asid = '0;
		wr_ps = '0;
		wr_addr = '0;
		wr_phys_addr = '0;
		wait (inRESET === 1'b1);
		@(negedge iCLOCK);
		check_value("rd_valid", rd_valid, 0);
		check_value("rd_hit", rd_hit, 0);

		// Every page size with both halves of the pair
		for (int k = 0; k < 5; k++) begin
			addr = $random(seed);
			addr[13 + k +: 2] = 2'(k);	// Spread over the sets
			asid = 14'($random(seed));
			phys = {$random(seed), $random(seed)};
			fill_line(addr, asid, k, phys);
			addr[12 + k] = 1'b0;
			read_check(addr, asid, k, 1'b1);
			addr[12 + k] = 1'b1;
			read_check(addr, asid, k, 1'b1);
		end
		read_check(addr, asid ^ 14'h1, 4, 1'b0);	// Foreign id
		read_check(32'hFFFF_F000, asid, 0, 1'b0);

		// Five fills and no reads take the last way twice
		flush_all();
		for (int t = 1; t <= 5; t++) begin
			fill_line(line_addr(t, 2), 14'h0005, 0, {2{32'(t) * 32'h0101_0101}});
		end
		for (int t = 1; t <= 5; t++) begin
			read_check(line_addr(t, 2), 14'h0005, 0, t != 4);
		end

		// Reads keep the first tag young, so the second goes
		flush_all();
		for (int t = 1; t <= 4; t++) begin
			fill_line(line_addr(t, 1), 14'h0007, 0, {2{32'(t) * 32'h1010_1010}});
		end
		read_check(line_addr(1, 1), 14'h0007, 0, 1'b1);
		read_check(line_addr(1, 1), 14'h0007, 0, 1'b1);
		fill_line(line_addr(5, 1), 14'h0007, 0, 64'h0005_5000_0005_5555);
		for (int t = 1; t <= 5; t++) begin
			read_check(line_addr(t, 1), 14'h0007, 0, t != 2);
		end

		flush_all();
		for (int t = 1; t <= 5; t++) begin
			read_check(line_addr(t, 1), 14'h0007, 0, 1'b0);
		end

		// Stall right after an accepted read
		fill_line(32'h0000_6000, 14'h0033, 0, 64'h0ABC_D123_4567_8FED);
		model_read(32'h0000_6000, 14'h0033, 0, hit, way);
		drive_read(32'h0000_6000, 14'h0033, 0);
		@(negedge iCLOCK);
		rd_stall = 1'b1;
		rd_addr = 32'h0000_4000;	// Never accepted
		repeat (3) begin
			@(negedge iCLOCK);
			check_value("rd_busy", rd_busy, 1);
			check_value("rd_valid", rd_valid, 0);
			check_value("rd_phys_addr", rd_phys_addr, 0);
			check_value("rd_flags", rd_flags, 0);
		end
		rd_stall = 1'b0;
		rd_req = 1'b0;
		#1;
		compare_result(hit, 2'd3, way, 1'b0);

		@(negedge iCLOCK);
		errors += tlb_top_i.protocol_chk_i.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: project.f
source/tlb_pkg.sv
source/tlb_if.sv
source/tlb_addr_split.sv
source/tlb_ctrl.sv
source/tlb_tag_array.sv
source/tlb_age_table.sv
source/tlb_data_array.sv
source/tlb_top.sv
bench/tlb_clkgen.sv
bench/tlb_chk.sv
bench/tlb_tb.sv

// File: Bender.yml
package:
  name: tlb

sources:
  - source/tlb_pkg.sv
  - source/tlb_if.sv
  - source/tlb_addr_split.sv
  - source/tlb_ctrl.sv
  - source/tlb_tag_array.sv
  - source/tlb_age_table.sv
  - source/tlb_data_array.sv
  - source/tlb_top.sv
  - target: simulation
    files:
      - bench/tlb_clkgen.sv
      - bench/tlb_chk.sv
      - bench/tlb_tb.sv
